// ==== mem_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types and widths for the data-memory stage
// data width is fixed at 32 bits, the lane logic assumes four lanes
//////////////////////////////////////////////////////////////////////

package mem_pkg;

    localparam int DATA_W = 32;
    localparam int LANES  = 4;

    // access opcodes, MEM_NONE is an idle slot
    typedef enum logic [3:0] {
        MEM_NONE    = 4'd0,
        MEM_READ32  = 4'd1,
        MEM_READ16  = 4'd2,
        MEM_READ16S = 4'd3,
        MEM_READ8   = 4'd4,
        MEM_READ8S  = 4'd5,
        MEM_WRITE32 = 4'd6,
        MEM_WRITE16 = 4'd7,
        MEM_WRITE8  = 4'd8
    } mem_op_t;

    // controller states
    typedef enum logic [1:0] {
        ST_CLEAR = 2'd0,
        ST_RUN   = 2'd1
    } ctrl_state_t;

endpackage

// ==== mem_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// sweep and request control for the data-memory stage
// requests are only taken in ST_RUN, anything else is dropped
// rd_valid follows rd_accept by exactly one cycle
//////////////////////////////////////////////////////////////////////

module mem_ctrl
    import mem_pkg::*;
#(
    parameter int ADDR_BITS = 6
)(
    input  logic    clk,
    input  logic    rst,
    input  logic    req,
    input  mem_op_t op,
    input  logic    clear_last,
    output logic    busy,
    output logic    clearing,
    output logic    cnt_en,
    output logic    wr_accept,
    output logic    rd_accept,
    output logic    rd_valid
);

    localparam int WORDS = 2 ** ADDR_BITS;

    ctrl_state_t state;
    logic        op_rd;
    logic        op_wr;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            state <= ST_CLEAR;
        else if (state == ST_CLEAR && clear_last)
            state <= ST_RUN;
    end

    // load or store class, MEM_NONE is neither
    always_comb
    begin
        op_rd = 1'b0;
        op_wr = 1'b0;
        case (op)
            MEM_READ32, MEM_READ16, MEM_READ16S, MEM_READ8, MEM_READ8S: op_rd = 1'b1;
            MEM_WRITE32, MEM_WRITE16, MEM_WRITE8:                       op_wr = 1'b1;
            default:                                                    op_rd = 1'b0;
        endcase
    end

    assign clearing  = (state == ST_CLEAR);
    assign busy      = clearing;
    assign cnt_en    = clearing;
    assign wr_accept = req && (state == ST_RUN) && op_wr;
    assign rd_accept = req && (state == ST_RUN) && op_rd;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            rd_valid <= 1'b0;
        else
            rd_valid <= rd_accept;
    end

    // sweep lasts one cycle per word after reset release
    a_sweep_len: assert property (@(posedge clk) disable iff (rst)
        $fell(rst) |-> ##(WORDS-1) clearing ##1 !clearing);
    a_no_valid_in_clear: assert property (@(posedge clk) disable iff (rst)
        clearing |-> !$rose(rd_valid));
    a_one_class: assert property (@(posedge clk) disable iff (rst)
        !(wr_accept && rd_accept));

endmodule

// ==== clear_counter.sv ====
//////////////////////////////////////////////////////////////////////
// word-address counter for the clear sweep after reset
// wraps to zero after the last word
//////////////////////////////////////////////////////////////////////

module clear_counter #(
    parameter int ADDR_BITS = 6
)(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cnt_en,
    output logic [ADDR_BITS-1:0] clear_addr,
    output logic                 clear_last
);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            clear_addr <= '0;
        else if (cnt_en)
            clear_addr <= clear_addr + 1'b1;
    end

    // final word of the array
    assign clear_last = (clear_addr == {ADDR_BITS{1'b1}});

    a_hold_when_idle: assert property (@(posedge clk) disable iff (rst)
        !cnt_en |=> $stable(clear_addr));

endmodule

// ==== store_align.sv ====
//////////////////////////////////////////////////////////////////////
// byte-lane enables and replicated write data for stores
// halfword stores ignore byte_off[0]; be stays zero without wr_accept
//////////////////////////////////////////////////////////////////////

module store_align
    import mem_pkg::*;
(
    input  mem_op_t           op,
    input  logic              wr_accept,
    input  logic [1:0]        byte_off,
    input  logic [DATA_W-1:0] wdata,
    output logic [LANES-1:0]  be,
    output logic [DATA_W-1:0] lane_wdata
);

    logic [LANES-1:0] lane_sel;

    always_comb
    begin
        lane_sel   = '0;
        lane_wdata = wdata;
        case (op)
            MEM_WRITE32:
            begin
                lane_sel = 4'b1111;
            end
            MEM_WRITE16:
            begin
                lane_sel   = byte_off[1] ? 4'b1100 : 4'b0011;
                lane_wdata = {2{wdata[15:0]}};
            end
            MEM_WRITE8:
            begin
                lane_sel   = 4'b0001 << byte_off;
                lane_wdata = {LANES{wdata[7:0]}};
            end
            default:
            begin
                lane_sel = '0;
            end
        endcase
    end

    assign be = wr_accept ? lane_sel : '0;

endmodule

// ==== data_mem.sv ====
//////////////////////////////////////////////////////////////////////
// word array with per-lane writes and a registered read
// read-first on a same-cycle write; clear writes override lane writes
// contents are undefined until the clear sweep has finished
//////////////////////////////////////////////////////////////////////

module data_mem
    import mem_pkg::*;
#(
    parameter int ADDR_BITS = 6
)(
    input  logic                 clk,
    input  logic                 clearing,
    input  logic [ADDR_BITS-1:0] clear_addr,
    input  logic [LANES-1:0]     be,
    input  logic [ADDR_BITS-1:0] word_addr,
    input  logic [DATA_W-1:0]    lane_wdata,
    output logic [DATA_W-1:0]    rd_word
);

    localparam int WORDS = 2 ** ADDR_BITS;

    logic [DATA_W-1:0] mem [0:WORDS-1];

    always_ff @(posedge clk)
    begin
        if (clearing)
        begin
            mem[clear_addr] <= '0;
        end
        else
        begin
            for (int i = 0; i < LANES; i++)
            begin
                if (be[i])
                    mem[word_addr][i*8 +: 8] <= lane_wdata[i*8 +: 8];
            end
        end
    end

    // read every cycle, load_extract decides when to use it
    always_ff @(posedge clk)
    begin
        rd_word <= mem[word_addr];
    end

    // stores must not race the sweep
    a_no_store_in_clear: assert property (@(posedge clk)
        clearing |-> (be == '0));

endmodule

// ==== load_extract.sv ====
//////////////////////////////////////////////////////////////////////
// field select and zero or sign extension for loads
// result is live in the rd_valid cycle, then held until the next load
// rd_data is zero after reset until the first load
//////////////////////////////////////////////////////////////////////

module load_extract
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rd_accept,
    input  mem_op_t           op,
    input  logic [1:0]        byte_off,
    input  logic [DATA_W-1:0] rd_word,
    output logic [DATA_W-1:0] rd_data
);

    mem_op_t           op_q;
    logic [1:0]        off_q;
    logic              pend;
    logic [DATA_W-1:0] held;
    logic [DATA_W-1:0] ext;
    logic [7:0]        fld8;
    logic [15:0]       fld16;

    always_ff @(posedge clk)
    begin
        if (rd_accept)
        begin
            op_q  <= op;
            off_q <= byte_off;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pend <= 1'b0;
            held <= '0;
        end
        else
        begin
            pend <= rd_accept;
            if (pend)
                held <= ext;
        end
    end

    assign fld8  = rd_word[off_q*8 +: 8];
    assign fld16 = off_q[1] ? rd_word[31:16] : rd_word[15:0];

    // sign is the top bit of the selected field
    always_comb
    begin
        case (op_q)
            MEM_READ32:  ext = rd_word;
            MEM_READ16:  ext = {16'b0, fld16};
            MEM_READ16S: ext = {{16{fld16[15]}}, fld16};
            MEM_READ8:   ext = {24'b0, fld8};
            MEM_READ8S:  ext = {{24{fld8[7]}}, fld8};
            default:     ext = '0;
        endcase
    end

    assign rd_data = pend ? ext : held;

endmodule

// ==== mem_unit.sv ====
//////////////////////////////////////////////////////////////////////
// data-memory stage of a 32-bit load/store core
// addresses wrap modulo 2**ADDR_BITS words, no misalignment traps
// busy is high during reset and the clear sweep that follows it
//////////////////////////////////////////////////////////////////////

module mem_unit
    import mem_pkg::*;
#(
    parameter int ADDR_BITS = 6
)(
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  mem_op_t           op,
    input  logic [31:0]       addr,
    input  logic [DATA_W-1:0] wdata,
    output logic              busy,
    output logic              rd_valid,
    output logic [DATA_W-1:0] rd_data
);

    logic                 clearing;
    logic                 cnt_en;
    logic                 wr_accept;
    logic                 rd_accept;
    logic [ADDR_BITS-1:0] clear_addr;
    logic                 clear_last;
    logic [LANES-1:0]     be;
    logic [DATA_W-1:0]    lane_wdata;
    logic [DATA_W-1:0]    rd_word;

    // requests during ST_CLEAR never reach the array, see mem_ctrl checks
    mem_ctrl #(.ADDR_BITS(ADDR_BITS)) i_mem_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .op         (op),
        .clear_last (clear_last),
        .busy       (busy),
        .clearing   (clearing),
        .cnt_en     (cnt_en),
        .wr_accept  (wr_accept),
        .rd_accept  (rd_accept),
        .rd_valid   (rd_valid)
    );

    clear_counter #(.ADDR_BITS(ADDR_BITS)) i_clear_counter (
        .clk        (clk),
        .rst        (rst),
        .cnt_en     (cnt_en),
        .clear_addr (clear_addr),
        .clear_last (clear_last)
    );

    store_align i_store_align (
        .op         (op),
        .wr_accept  (wr_accept),
        .byte_off   (addr[1:0]),
        .wdata      (wdata),
        .be         (be),
        .lane_wdata (lane_wdata)
    );

    data_mem #(.ADDR_BITS(ADDR_BITS)) i_data_mem (
        .clk        (clk),
        .clearing   (clearing),
        .clear_addr (clear_addr),
        .be         (be),
        .word_addr  (addr[ADDR_BITS+1:2]),
        .lane_wdata (lane_wdata),
        .rd_word    (rd_word)
    );

    load_extract i_load_extract (
        .clk        (clk),
        .rst        (rst),
        .rd_accept  (rd_accept),
        .op         (op),
        .byte_off   (addr[1:0]),
        .rd_word    (rd_word),
        .rd_data    (rd_data)
    );

endmodule

// ==== tb_mem_unit.sv ====
//////////////////////////////////////////////////////////////////////
// table-driven testbench for mem_unit with ADDR_BITS = 4
// one request per cycle, expected loads come from a shadow memory
//////////////////////////////////////////////////////////////////////

module tb_mem_unit
    import mem_pkg::*;
();

    localparam int ADDR_BITS  = 4;
    localparam int WORDS      = 2 ** ADDR_BITS;
    localparam int IDLE_LIMIT = 4 * WORDS;

    logic        clk;
    logic        rst;
    logic        req;
    mem_op_t     op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        busy;
    logic        rd_valid;
    logic [31:0] rd_data;

    logic [31:0] shadow [0:WORDS-1];
    logic [31:0] rng;
    logic [31:0] last_rd;

    // stimulus table, one row per cycle
    string       t_name  [$];
    mem_op_t     t_op    [$];
    logic [31:0] t_addr  [$];
    logic [31:0] t_wdata [$];
    logic [31:0] t_exp   [$];
    bit          t_rd    [$];

    mem_unit #(.ADDR_BITS(ADDR_BITS)) i_mem_unit (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .op       (op),
        .addr     (addr),
        .wdata    (wdata),
        .busy     (busy),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        begin
            $display("%s", why);
            $display("TB FAILED");
            $fatal(1, "run aborted");
        end
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        begin
            if (actual !== expected)
                abort_run($sformatf("ERR %s expected %08h actual %08h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        begin
            s = x ^ (x << 13);
            s = s ^ (s >> 17);
            s = s ^ (s << 5);
            return s;
        end
    endfunction

    // byte address to word index, wrapping modulo the array size
    function automatic int word_index(input logic [31:0] a);
        begin
            return (a >> 2) % WORDS;
        end
    endfunction

    function automatic logic [31:0] model_load(input mem_op_t o, input logic [31:0] a);
        logic [31:0] w;
        logic [31:0] sh;
        logic [15:0] h;
        logic [7:0]  b;
        begin
            w  = shadow[word_index(a)];
            sh = w >> {a[1:0], 3'b000};
            b  = sh[7:0];
            h  = a[1] ? w[31:16] : w[15:0];
            case (o)
                MEM_READ16:  return {16'h0, h};
                MEM_READ16S: return {{16{h[15]}}, h};
                MEM_READ8:   return {24'h0, b};
                MEM_READ8S:  return {{24{b[7]}}, b};
                default:     return w;
            endcase
        end
    endfunction

    task automatic model_store(input mem_op_t o, input logic [31:0] a, input logic [31:0] d);
        int idx;
        begin
            idx = word_index(a);
            case (o)
                MEM_WRITE32: shadow[idx] = d;
                MEM_WRITE16:
                begin
                    if (a[1])
                        shadow[idx][31:16] = d[15:0];
                    else
                        shadow[idx][15:0] = d[15:0];
                end
                MEM_WRITE8:  shadow[idx][{a[1:0], 3'b000} +: 8] = d[7:0];
                default:     ;
            endcase
        end
    endtask

    task automatic add_entry(input string name, input mem_op_t o, input logic [31:0] a,
                             input logic [31:0] d);
        begin
            t_name.push_back(name);
            t_op.push_back(o);
            t_addr.push_back(a);
            t_wdata.push_back(d);
            if (o inside {MEM_READ32, MEM_READ16, MEM_READ16S, MEM_READ8, MEM_READ8S})
            begin
                t_rd.push_back(1'b1);
                t_exp.push_back(model_load(o, a));
            end
            else
            begin
                t_rd.push_back(1'b0);
                t_exp.push_back(32'h0);
                model_store(o, a, d);
            end
        end
    endtask

    task automatic clear_table();
        begin
            t_name.delete();
            t_op.delete();
            t_addr.delete();
            t_wdata.delete();
            t_exp.delete();
            t_rd.delete();
        end
    endtask

    // outputs seen after the edge that sampled row k
    task automatic check_slot(input int k);
        begin
            check({t_name[k], " busy"}, 32'h0, {31'b0, busy});
            check({t_name[k], " rd_valid"}, {31'b0, t_rd[k]}, {31'b0, rd_valid});
            if (t_rd[k])
                last_rd = t_exp[k];
            check(t_name[k], last_rd, rd_data);
        end
    endtask

    task automatic run_table();
        int n;
        begin
            n = t_op.size();
            for (int i = 0; i <= n; i++)
            begin
                @(posedge clk);
                if (i < n)
                begin
                    req   <= 1'b1;
                    op    <= t_op[i];
                    addr  <= t_addr[i];
                    wdata <= t_wdata[i];
                end
                else
                begin
                    req <= 1'b0;
                    op  <= MEM_NONE;
                end
                @(negedge clk);
                if (i > 0)
                    check_slot(i - 1);
            end
        end
    endtask

    task automatic wait_idle();
        int n;
        begin
            n = 0;
            while (busy !== 1'b0)
            begin
                @(negedge clk);
                n++;
                check("sweep rd_valid", 32'h0, {31'b0, rd_valid});
                if (n > IDLE_LIMIT)
                    abort_run("timeout: busy did not fall after the clear sweep");
            end
        end
    endtask

    // 8 reset cycles, then half the sweep; optional requests meant to be dropped
    task automatic apply_reset(input bit with_traffic);
        begin
            @(posedge clk);
            rst   <= 1'b1;
            req   <= with_traffic;
            op    <= MEM_WRITE32;
            addr  <= 32'h0;
            wdata <= 32'hffff_ffff;
            for (int k = 0; k < 8 + WORDS / 2; k++)
            begin
                @(posedge clk);
                if (k == 7)
                    rst <= 1'b0;
                op   <= k[0] ? MEM_READ32 : MEM_WRITE32;
                // aim at a word the sweep has already cleared
                addr <= 4 * ((k + WORDS - 8) % WORDS);
                @(negedge clk);
                check("reset busy", 32'h1, {31'b0, busy});
                check("reset rd_valid", 32'h0, {31'b0, rd_valid});
            end
            @(posedge clk);
            req <= 1'b0;
            op  <= MEM_NONE;
            wait_idle();
            check("sweep rd_data", 32'h0, rd_data);
            last_rd = 32'h0;
            for (int w = 0; w < WORDS; w++)
                shadow[w] = 32'h0;
        end
    endtask

    task automatic build_main_table();
        mem_op_t rd_ops [4];
        begin
            rd_ops = '{MEM_READ16, MEM_READ16S, MEM_READ8, MEM_READ8S};
            for (int w = 0; w < WORDS; w++)
                add_entry($sformatf("clear w%0d", w), MEM_READ32, 4 * w, 32'h0);
            for (int w = 0; w < WORDS; w++)
            begin
                rng = xorshift32(rng);
                add_entry($sformatf("store w%0d", w), MEM_WRITE32, 4 * w, rng);
            end
            // word 65 lands on word 1
            rng = xorshift32(rng);
            add_entry("store wrap", MEM_WRITE32, 32'h0000_0104, rng);
            for (int w = 0; w < WORDS; w++)
                add_entry($sformatf("load w%0d", w), MEM_READ32, 4 * w, 32'h0);
            for (int off = 0; off < 4; off++)
            begin
                rng = xorshift32(rng);
                add_entry($sformatf("st8 off%0d", off), MEM_WRITE8, 8 + off, rng);
                add_entry($sformatf("merge8 off%0d", off), MEM_READ32, 8, 32'h0);
                rng = xorshift32(rng);
                add_entry($sformatf("st16 off%0d", off), MEM_WRITE16, 12 + off, rng);
                add_entry($sformatf("merge16 off%0d", off), MEM_READ32, 12, 32'h0);
            end
            // each byte and half gets a set and a clear top bit across the two words
            add_entry("ext w4 init", MEM_WRITE32, 32'h10, 32'h7f80_8001);
            add_entry("ext w5 init", MEM_WRITE32, 32'h14, 32'h8001_7fff);
            for (int w = 4; w < 6; w++)
                for (int off = 0; off < 4; off++)
                    for (int j = 0; j < 4; j++)
                        add_entry($sformatf("%s w%0d off%0d", rd_ops[j].name(), w, off),
                                  rd_ops[j], 4 * w + off, 32'h0);
            rng = xorshift32(rng);
            add_entry("b2b st32", MEM_WRITE32, 32'h18, rng);
            add_entry("b2b ld32", MEM_READ32, 32'h18, 32'h0);
            rng = xorshift32(rng);
            add_entry("b2b st8", MEM_WRITE8, 32'h1b, rng);
            add_entry("b2b ld8s", MEM_READ8S, 32'h1b, 32'h0);
            add_entry("b2b ld16", MEM_READ16, 32'h1a, 32'h0);
            rng = xorshift32(rng);
            add_entry("b2b st16", MEM_WRITE16, 32'h18, rng);
            add_entry("b2b ld16s", MEM_READ16S, 32'h18, 32'h0);
            add_entry("b2b ld32 wrap", MEM_READ32, 32'h58, 32'h0);
            rng = xorshift32(rng);
            add_entry("none w7", MEM_NONE, 32'h1c, rng);
            add_entry("none hold", MEM_NONE, 32'h1c, rng);
            add_entry("none w7 check", MEM_READ32, 32'h1c, 32'h0);
        end
    endtask

    initial
    begin
        clk     = 1'b0;
        rst     = 1'b1;
        req     = 1'b0;
        op      = MEM_NONE;
        addr    = 32'h0;
        wdata   = 32'h0;
        rng     = 32'h26d9;
        last_rd = 32'h0;
        apply_reset(1'b0);
        build_main_table();
        run_table();
        // second sweep with requests issued while busy
        apply_reset(1'b1);
        clear_table();
        for (int w = 0; w < WORDS; w++)
            add_entry($sformatf("reclear w%0d", w), MEM_READ32, 4 * w, 32'h0);
        run_table();
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== mem_unit.f ====
mem_pkg.sv
mem_ctrl.sv
clear_counter.sv
store_align.sv
data_mem.sv
load_extract.sv
mem_unit.sv
tb_mem_unit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the mem_unit testbench with Verilator, verdict from the log
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_mem_unit -o tb_mem_unit_sim \
    -f mem_unit.f || { echo "build failed"; exit 1; }
./obj_dir/tb_mem_unit_sim > sim.log 2>&1
grep -q "TB PASSED" sim.log && echo "simulation passed" || { cat sim.log; exit 1; }
